// File: include/bwt_consts.svh
`ifndef BWT_CONSTS_SVH
`define BWT_CONSTS_SVH

// ------------------------------------------------------------
// forward extension limits
// ------------------------------------------------------------
`define BWT_LEN 101 // forward extension stops at this position

`define BWT_READ_NUM_W 10 // read number tag
`define BWT_PTR_W 7 // curr pointer, forward_i, min_intv, backward_x

// unstalled cycles from the seed stage output to the candidate intervals
`define BWT_OCC_LATENCY 12

// ------------------------------------------------------------
// DRAM line address taken out of k and l
// ------------------------------------------------------------
`define BWT_ADDR_HI 34
`define BWT_ADDR_LO 7 // four zero bits are appended below the slice

`endif

// File: logic/bwt_pkg.sv
`include "bwt_consts.svh"

package bwt_pkg;

	// context status, shared with the backward pipeline
	typedef enum logic [5:0] {
		F_INIT  = 6'd0, // first pass, no candidate yet
		F_RUN   = 6'd1,
		F_BREAK = 6'd2,
		BCK_INI = 6'd4, // handed over to backward extension
		BUBBLE  = 6'h30 // empty slot
	} status_e;

	// bi-interval of the FM-index
	typedef struct packed {
		logic [63:0] x0;
		logic [63:0] x1;
		logic [63:0] x2; // interval size
	} bi_intv_t;

	// one candidate per base, index 0 is A
	typedef bi_intv_t [3:0] cand_vec_t;

	typedef struct packed {
		status_e                    status;
		logic [7:0]                 query;
		logic [`BWT_PTR_W-1:0]      ptr_curr;
		logic [`BWT_READ_NUM_W-1:0] read_num;
		bi_intv_t                   ik;
		logic [63:0]                ik_info;
		logic [`BWT_PTR_W-1:0]      forward_i;
		logic [`BWT_PTR_W-1:0]      min_intv;
		logic [`BWT_PTR_W-1:0]      backward_x;
	} fwd_ctx_t;

endpackage

// File: logic/fwd_seed_stage.sv
`include "bwt_consts.svh"

module fwd_seed_stage (
	input  logic                       Clk_32UI,
	input  logic                       reset_BWT_extend,
	input  logic                       stall_i,
	input  logic [63:0]                primary_i,
	input  bwt_pkg::status_e           status_i,
	input  logic [7:0]                 query_i,
	input  logic [`BWT_PTR_W-1:0]      ptr_curr_i,
	input  logic [`BWT_READ_NUM_W-1:0] read_num_i,
	input  bwt_pkg::bi_intv_t          ik_i,
	input  logic [63:0]                ik_info_i,
	input  logic [`BWT_PTR_W-1:0]      forward_i_i,
	input  logic [`BWT_PTR_W-1:0]      min_intv_i,
	input  logic [`BWT_PTR_W-1:0]      backward_x_i,
	output bwt_pkg::fwd_ctx_t          ctx_o,
	output logic                       all_done_o,
	output logic [63:0]                k_o,
	output logic [63:0]                l_o
);

	logic        read_done;
	logic [63:0] k_raw;
	logic [63:0] l_raw;

	assign read_done = (status_i == bwt_pkg::F_RUN) && (forward_i_i >= `BWT_LEN);
	assign k_raw     = ik_i.x1 - 64'd1;
	assign l_raw     = k_raw + ik_i.x2;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			ctx_o.status <= bwt_pkg::BUBBLE;
			all_done_o   <= 1'b0;
		end else if (!stall_i) begin
			ctx_o.status     <= read_done ? bwt_pkg::F_BREAK : status_i; // end of read
			all_done_o       <= read_done;
			ctx_o.query      <= query_i;
			ctx_o.ptr_curr   <= ptr_curr_i;
			ctx_o.read_num   <= read_num_i;
			ctx_o.ik         <= ik_i;
			ctx_o.ik_info    <= ik_info_i;
			ctx_o.forward_i  <= forward_i_i;
			ctx_o.min_intv   <= min_intv_i;
			ctx_o.backward_x <= backward_x_i;
			k_o              <= (k_raw >= primary_i) ? k_raw - 64'd1 : k_raw; // skip primary
			l_o              <= (l_raw >= primary_i) ? l_raw - 64'd1 : l_raw;
		end
	end

endmodule

// File: logic/ctx_delay_line.sv
`include "bwt_consts.svh"

module ctx_delay_line #(
	parameter int  DEPTH = `BWT_OCC_LATENCY,
	parameter type T     = bwt_pkg::fwd_ctx_t
) (
	input  logic Clk_32UI,
	input  logic reset_BWT_extend,
	input  logic stall_i,
	input  T     data_i,
	output T     data_o,
	output logic run_o,
	output logic break_o,
	output logic at_len_o
);

	T pipe_q  [DEPTH];
	T slot_in [DEPTH];

	always_comb begin
		slot_in[0] = data_i;
		for (int i = 1; i < DEPTH; i++) begin
			slot_in[i] = pipe_q[i-1];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe_q[i].status <= bwt_pkg::BUBBLE;
			end
			run_o    <= 1'b0;
			break_o  <= 1'b0;
			at_len_o <= 1'b0;
		end else if (!stall_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				pipe_q[i] <= slot_in[i];
			end
			// flags settle together with the last slot
			run_o    <= slot_in[DEPTH-1].status == bwt_pkg::F_RUN;
			break_o  <= slot_in[DEPTH-1].status == bwt_pkg::F_BREAK;
			at_len_o <= slot_in[DEPTH-1].forward_i == `BWT_LEN;
		end
	end

	assign data_o = pipe_q[DEPTH-1];

endmodule

// File: logic/fwd_decide_stage.sv
`include "bwt_consts.svh"

module fwd_decide_stage (
	input  logic                       Clk_32UI,
	input  logic                       reset_BWT_extend,
	input  logic                       stall_i,
	input  bwt_pkg::fwd_ctx_t          ctx_i,
	input  logic                       run_i,
	input  logic                       break_i,
	input  logic                       at_len_i,
	input  bwt_pkg::cand_vec_t         cand_i,
	output bwt_pkg::fwd_ctx_t          ctx_o,
	output bwt_pkg::cand_vec_t         cand_o,
	output logic                       update_ik_o,
	output logic                       add_i_o,
	output logic                       curr_we_o,
	output logic [`BWT_PTR_W-1:0]      curr_addr_o,
	output logic [255:0]               curr_data_o,
	output logic [`BWT_READ_NUM_W-1:0] curr_read_num_o,
	output logic                       ret_valid_o,
	output logic [`BWT_PTR_W-1:0]      ret_o,
	output logic [`BWT_READ_NUM_W-1:0] ret_read_num_o
);

	bwt_pkg::bi_intv_t     cand_sel;
	logic [`BWT_PTR_W-1:0] ptr_inc;

	assign cand_sel = cand_i[~ctx_i.query[1:0]]; // complement base, 3-q
	assign ptr_inc  = ctx_i.ptr_curr + 1'b1;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			ctx_o.status <= bwt_pkg::BUBBLE;
			curr_we_o    <= 1'b0;
			ret_valid_o  <= 1'b0;
			update_ik_o  <= 1'b0;
			add_i_o      <= 1'b0;
		end else if (!stall_i) begin
			ctx_o           <= ctx_i; // status and ptr_curr overridden below
			cand_o          <= cand_i;
			curr_addr_o     <= ctx_i.ptr_curr;
			curr_read_num_o <= ctx_i.read_num;
			curr_data_o     <= {ctx_i.ik_info, ctx_i.ik.x2, ctx_i.ik.x1, ctx_i.ik.x0};
			ret_o           <= ctx_i.ik_info[`BWT_PTR_W-1:0];
			ret_read_num_o  <= ctx_i.read_num;

			// ------------------------------------------------------------
			if (run_i) begin
				ret_valid_o <= 1'b0;
				if (cand_sel.x2 != ctx_i.ik.x2) begin // interval shrinks, save ik
					curr_we_o      <= 1'b1;
					ctx_o.ptr_curr <= ptr_inc;
					if (cand_sel.x2 < ctx_i.min_intv) begin
						ctx_o.status <= bwt_pkg::F_BREAK; // keep old ik
						update_ik_o  <= 1'b0;
						add_i_o      <= 1'b0;
					end else begin
						update_ik_o <= 1'b1;
						add_i_o     <= 1'b1;
					end
				end else begin
					curr_we_o   <= 1'b0;
					update_ik_o <= 1'b1;
					add_i_o     <= 1'b1;
				end
			end else if (break_i) begin
				// read finished, report and hand over
				curr_we_o <= at_len_i;
				if (at_len_i) begin
					ctx_o.ptr_curr <= ptr_inc;
				end
				ret_valid_o  <= 1'b1;
				ctx_o.status <= bwt_pkg::BCK_INI;
				update_ik_o  <= 1'b0;
				add_i_o      <= 1'b0;
			end else begin
				curr_we_o   <= 1'b0;
				ret_valid_o <= 1'b0;
				update_ik_o <= 1'b0;
				add_i_o     <= 1'b0;
			end
		end
	end

endmodule

// File: logic/fwd_update_stage.sv
`include "bwt_consts.svh"

module fwd_update_stage (
	input  logic                       Clk_32UI,
	input  logic                       reset_BWT_extend,
	input  logic                       stall_i,
	input  logic [63:0]                primary_i,
	input  bwt_pkg::fwd_ctx_t          ctx_i,
	input  bwt_pkg::cand_vec_t         cand_i,
	input  logic                       update_ik_i,
	input  logic                       add_i_i,
	output bwt_pkg::fwd_ctx_t          ctx_o,
	output logic [63:0]                k_o,
	output logic [63:0]                l_o,
	output bwt_pkg::status_e           query_status_o,
	output logic [`BWT_READ_NUM_W-1:0] query_read_num_o,
	output logic [`BWT_PTR_W-1:0]      next_query_pos_o
);

	bwt_pkg::bi_intv_t cand_sel;
	bwt_pkg::bi_intv_t next_ik;
	logic              take_cand;
	logic [63:0]       k_nxt;
	logic [63:0]       l_nxt;

	bwt_pkg::fwd_ctx_t ctx2_q;
	logic [63:0]       k2_q;
	logic [63:0]       l2_q;
	logic [63:0]       k2_m1_q;
	logic [63:0]       l2_m1_q;

	assign cand_sel  = cand_i[~ctx_i.query[1:0]];
	assign take_cand = (ctx_i.status == bwt_pkg::F_RUN) && update_ik_i;
	assign next_ik   = take_cand ? cand_sel : ctx_i.ik;
	assign k_nxt     = next_ik.x1 - 64'd1;
	assign l_nxt     = k_nxt + next_ik.x2;

	// ------------------------------------------------------------
	// L2, new ik and both k/l variants
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			ctx2_q.status <= bwt_pkg::BUBBLE;
		end else if (!stall_i) begin
			ctx2_q    <= ctx_i;
			ctx2_q.ik <= next_ik;
			if (take_cand) begin
				ctx2_q.ik_info <= 64'(ctx_i.forward_i) + 64'd1; // ik.info = i + 1
			end
			if (add_i_i) begin
				ctx2_q.forward_i <= ctx_i.forward_i + 1'b1;
			end
			k2_q    <= k_nxt;
			l2_q    <= l_nxt;
			k2_m1_q <= k_nxt - 64'd1; // used when past primary
			l2_m1_q <= l_nxt - 64'd1;
		end
	end

	// ------------------------------------------------------------
	// L22, primary correction and early query request
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			ctx_o.status   <= bwt_pkg::BUBBLE;
			query_status_o <= bwt_pkg::BUBBLE;
		end else if (!stall_i) begin
			ctx_o            <= ctx2_q;
			k_o              <= (k2_q >= primary_i) ? k2_m1_q : k2_q;
			l_o              <= (l2_q >= primary_i) ? l2_m1_q : l2_q;
			query_status_o   <= ctx2_q.status; // one cycle ahead of dram request
			query_read_num_o <= ctx2_q.read_num;
			next_query_pos_o <= ctx2_q.forward_i;
		end
	end

endmodule

// File: logic/mem_issue_stage.sv
`include "bwt_consts.svh"

module mem_issue_stage (
	input  logic              Clk_32UI,
	input  logic              reset_BWT_extend,
	input  logic              stall_i,
	input  bwt_pkg::fwd_ctx_t ctx_i,
	input  logic [63:0]       k_i,
	input  logic [63:0]       l_i,
	output logic              dram_valid_o,
	output logic [31:0]       addr_k_o,
	output logic [31:0]       addr_l_o,
	output bwt_pkg::fwd_ctx_t ctx_o
);

	logic issue;

	// a broken read needs no memory access
	assign issue = (ctx_i.status == bwt_pkg::F_INIT) || (ctx_i.status == bwt_pkg::F_RUN);

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			ctx_o.status <= bwt_pkg::BUBBLE;
			dram_valid_o <= 1'b0;
		end else if (!stall_i) begin
			if (issue) begin
				dram_valid_o <= 1'b1;
				addr_k_o     <= {k_i[`BWT_ADDR_HI:`BWT_ADDR_LO], 4'b0}; // line address
				addr_l_o     <= {l_i[`BWT_ADDR_HI:`BWT_ADDR_LO], 4'b0};
			end else begin
				dram_valid_o <= 1'b0;
				addr_k_o     <= 32'd0;
				addr_l_o     <= 32'd0;
			end

			ctx_o <= ctx_i;
			if (ctx_i.status == bwt_pkg::F_INIT) begin
				ctx_o.status <= bwt_pkg::F_RUN; // first lookup issued
			end
		end
	end

endmodule

// File: logic/fwd_extend_top.sv
`include "bwt_consts.svh"

module fwd_extend_top (
	input  logic                       Clk_32UI,
	input  logic                       reset_BWT_extend,
	input  logic                       stall_i,
	input  logic [63:0]                primary_i,
	input  bwt_pkg::status_e           status_i,
	input  logic [7:0]                 query_i,
	input  logic [`BWT_PTR_W-1:0]      ptr_curr_i,
	input  logic [`BWT_READ_NUM_W-1:0] read_num_i,
	input  bwt_pkg::bi_intv_t          ik_i,
	input  logic [63:0]                ik_info_i,
	input  logic [`BWT_PTR_W-1:0]      forward_i_i,
	input  logic [`BWT_PTR_W-1:0]      min_intv_i,
	input  logic [`BWT_PTR_W-1:0]      backward_x_i,
	// occurrence engine
	output logic [63:0]                occ_k_o,
	output logic [63:0]                occ_l_o,
	output logic                       occ_done_o,
	input  bwt_pkg::cand_vec_t         cand_i,
	// DRAM request and outgoing context
	output logic                       dram_valid_o,
	output logic [31:0]                addr_k_o,
	output logic [31:0]                addr_l_o,
	output bwt_pkg::status_e           status_o,
	output logic [7:0]                 query_o,
	output logic [`BWT_PTR_W-1:0]      ptr_curr_o,
	output logic [`BWT_READ_NUM_W-1:0] read_num_o,
	output bwt_pkg::bi_intv_t          ik_o,
	output logic [63:0]                ik_info_o,
	output logic [`BWT_PTR_W-1:0]      forward_i_o,
	output logic [`BWT_PTR_W-1:0]      min_intv_o,
	output logic [`BWT_PTR_W-1:0]      backward_x_o,
	// next query request
	output bwt_pkg::status_e           query_status_o,
	output logic [`BWT_READ_NUM_W-1:0] query_read_num_o,
	output logic [`BWT_PTR_W-1:0]      next_query_pos_o,
	// curr queue and return
	output logic                       curr_we_o,
	output logic [`BWT_READ_NUM_W-1:0] curr_read_num_o,
	output logic [`BWT_PTR_W-1:0]      curr_addr_o,
	output logic [255:0]               curr_data_o,
	output logic                       ret_valid_o,
	output logic [`BWT_PTR_W-1:0]      ret_o,
	output logic [`BWT_READ_NUM_W-1:0] ret_read_num_o
);

	bwt_pkg::fwd_ctx_t  seed_ctx;
	bwt_pkg::fwd_ctx_t  dly_ctx;
	bwt_pkg::fwd_ctx_t  dec_ctx;
	bwt_pkg::fwd_ctx_t  upd_ctx;
	bwt_pkg::fwd_ctx_t  out_ctx;
	bwt_pkg::cand_vec_t dec_cand;
	logic               dly_run;
	logic               dly_break;
	logic               dly_at_len;
	logic               update_ik;
	logic               add_i;
	logic [63:0]        upd_k;
	logic [63:0]        upd_l;

	fwd_seed_stage u_seed (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.primary_i        (primary_i),
		.status_i         (status_i),
		.query_i          (query_i),
		.ptr_curr_i       (ptr_curr_i),
		.read_num_i       (read_num_i),
		.ik_i             (ik_i),
		.ik_info_i        (ik_info_i),
		.forward_i_i      (forward_i_i),
		.min_intv_i       (min_intv_i),
		.backward_x_i     (backward_x_i),
		.ctx_o            (seed_ctx),
		.all_done_o       (occ_done_o),
		.k_o              (occ_k_o),
		.l_o              (occ_l_o)
	);

	// context waits here while the occurrence engine runs
	ctx_delay_line #(
		.DEPTH (`BWT_OCC_LATENCY),
		.T     (bwt_pkg::fwd_ctx_t)
	) u_ctx_delay (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.data_i           (seed_ctx),
		.data_o           (dly_ctx),
		.run_o            (dly_run),
		.break_o          (dly_break),
		.at_len_o         (dly_at_len)
	);

	fwd_decide_stage u_decide (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.ctx_i            (dly_ctx),
		.run_i            (dly_run),
		.break_i          (dly_break),
		.at_len_i         (dly_at_len),
		.cand_i           (cand_i),
		.ctx_o            (dec_ctx),
		.cand_o           (dec_cand),
		.update_ik_o      (update_ik),
		.add_i_o          (add_i),
		.curr_we_o        (curr_we_o),
		.curr_addr_o      (curr_addr_o),
		.curr_data_o      (curr_data_o),
		.curr_read_num_o  (curr_read_num_o),
		.ret_valid_o      (ret_valid_o),
		.ret_o            (ret_o),
		.ret_read_num_o   (ret_read_num_o)
	);

	fwd_update_stage u_update (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.primary_i        (primary_i),
		.ctx_i            (dec_ctx),
		.cand_i           (dec_cand),
		.update_ik_i      (update_ik),
		.add_i_i          (add_i),
		.ctx_o            (upd_ctx),
		.k_o              (upd_k),
		.l_o              (upd_l),
		.query_status_o   (query_status_o),
		.query_read_num_o (query_read_num_o),
		.next_query_pos_o (next_query_pos_o)
	);

	mem_issue_stage u_issue (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.stall_i          (stall_i),
		.ctx_i            (upd_ctx),
		.k_i              (upd_k),
		.l_i              (upd_l),
		.dram_valid_o     (dram_valid_o),
		.addr_k_o         (addr_k_o),
		.addr_l_o         (addr_l_o),
		.ctx_o            (out_ctx)
	);

	// ------------------------------------------------------------
	assign status_o     = out_ctx.status;
	assign query_o      = out_ctx.query;
	assign ptr_curr_o   = out_ctx.ptr_curr;
	assign read_num_o   = out_ctx.read_num;
	assign ik_o         = out_ctx.ik;
	assign ik_info_o    = out_ctx.ik_info;
	assign forward_i_o  = out_ctx.forward_i;
	assign min_intv_o   = out_ctx.min_intv;
	assign backward_x_o = out_ctx.backward_x;

endmodule

// File: test/fwd_extend_tb.sv
`include "bwt_consts.svh"

module fwd_extend_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [63:0] PRIMARY = 64'h0000_0002_4000_0000;
	localparam int N_RANDOM = 60;
	localparam int N_REQ = 10 + N_RANDOM; // directed plus random requests
	localparam int CYCLE_LIMIT = N_REQ * 17 + N_RANDOM + 200; // stalls at most one per request
	localparam int DRAIN = 18;

	typedef struct packed {
		bwt_pkg::status_e           status;
		logic [7:0]                 query;
		logic [`BWT_PTR_W-1:0]      ptr;
		logic [`BWT_READ_NUM_W-1:0] rn;
		bwt_pkg::bi_intv_t          ik;
		logic [63:0]                info;
		logic [`BWT_PTR_W-1:0]      fwd;
		logic [`BWT_PTR_W-1:0]      min;
		logic [`BWT_PTR_W-1:0]      bx;
		bwt_pkg::cand_vec_t         cand;
	} req_t;

	typedef struct packed {
		logic                       live;
		logic                       occ_done;
		logic [63:0]                occ_k;
		logic [63:0]                occ_l;
		logic                       curr_we;
		logic [`BWT_PTR_W-1:0]      curr_addr;
		logic [255:0]               curr_data;
		logic [`BWT_READ_NUM_W-1:0] curr_rn;
		logic                       ret_valid;
		logic [`BWT_PTR_W-1:0]      ret;
		bwt_pkg::status_e           q_status;
		logic [`BWT_PTR_W-1:0]      q_pos;
		logic                       dram_valid;
		logic [31:0]                addr_k;
		logic [31:0]                addr_l;
		bwt_pkg::status_e           st_out;
		bwt_pkg::bi_intv_t          ik;
		logic [63:0]                ik_info;
		logic [`BWT_PTR_W-1:0]      ptr;
		logic [`BWT_PTR_W-1:0]      fwd;
		logic [`BWT_READ_NUM_W-1:0] rn;
		logic [7:0]                 query;
		logic [`BWT_PTR_W-1:0]      min;
		logic [`BWT_PTR_W-1:0]      bx;
	} exp_t;

	logic                       Clk_32UI;
	logic                       reset_BWT_extend;
	logic                       stall_i;
	logic [63:0]                primary_i;
	bwt_pkg::status_e           status_i;
	logic [7:0]                 query_i;
	logic [`BWT_PTR_W-1:0]      ptr_curr_i;
	logic [`BWT_READ_NUM_W-1:0] read_num_i;
	bwt_pkg::bi_intv_t          ik_i;
	logic [63:0]                ik_info_i;
	logic [`BWT_PTR_W-1:0]      forward_i_i;
	logic [`BWT_PTR_W-1:0]      min_intv_i;
	logic [`BWT_PTR_W-1:0]      backward_x_i;
	bwt_pkg::cand_vec_t         cand_i;
	logic [63:0]                occ_k_o;
	logic [63:0]                occ_l_o;
	logic                       occ_done_o;
	logic                       dram_valid_o;
	logic [31:0]                addr_k_o;
	logic [31:0]                addr_l_o;
	bwt_pkg::status_e           status_o;
	logic [7:0]                 query_o;
	logic [`BWT_PTR_W-1:0]      ptr_curr_o;
	logic [`BWT_READ_NUM_W-1:0] read_num_o;
	bwt_pkg::bi_intv_t          ik_o;
	logic [63:0]                ik_info_o;
	logic [`BWT_PTR_W-1:0]      forward_i_o;
	logic [`BWT_PTR_W-1:0]      min_intv_o;
	logic [`BWT_PTR_W-1:0]      backward_x_o;
	bwt_pkg::status_e           query_status_o;
	logic [`BWT_READ_NUM_W-1:0] query_read_num_o;
	logic [`BWT_PTR_W-1:0]      next_query_pos_o;
	logic                       curr_we_o;
	logic [`BWT_READ_NUM_W-1:0] curr_read_num_o;
	logic [`BWT_PTR_W-1:0]      curr_addr_o;
	logic [255:0]               curr_data_o;
	logic                       ret_valid_o;
	logic [`BWT_PTR_W-1:0]      ret_o;
	logic [`BWT_READ_NUM_W-1:0] ret_read_num_o;

	bwt_pkg::cand_vec_t cand_pipe [`BWT_OCC_LATENCY+1]; // occurrence engine latency
	bwt_pkg::cand_vec_t cur_cand;
	exp_t               exp_q [$];
	logic [31:0]        lcg_state = 32'd65;
	int                 adv = 0; // unstalled edges since reset release
	int                 cycle_cnt = 0;
	int                 req_count = 0;
	int                 n_checks = 0;
	int                 n_errors = 0;
	int                 test_errors = 0;
	int                 n_stalls = 0;
	logic               checking = 1'b0;

	fwd_extend_top u_dut (.*);

	initial Clk_32UI = 1'b0;
	always #4 Clk_32UI = ~Clk_32UI;

	// ------------------------------------------------------------
	// occurrence engine model, advances with the pipeline
	// ------------------------------------------------------------
	always @(posedge Clk_32UI) begin
		if (reset_BWT_extend && !stall_i) begin
			for (int i = `BWT_OCC_LATENCY; i > 0; i--) begin
				cand_pipe[i] <= cand_pipe[i-1];
			end
			cand_pipe[0] <= cur_cand;
			adv          <= adv + 1;
		end
	end

	assign cand_i = cand_pipe[`BWT_OCC_LATENCY];

	always @(posedge Clk_32UI) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the test sequence did not complete", cycle_cnt);
			$display("Result: FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic bwt_pkg::bi_intv_t intv(logic [63:0] x0, logic [63:0] x1, logic [63:0] x2);
		bwt_pkg::bi_intv_t v;
		v.x0 = x0;
		v.x1 = x1;
		v.x2 = x2;
		return v;
	endfunction

	// candidate for base b shrinks by b plus the offset
	function automatic bwt_pkg::cand_vec_t make_cand(bwt_pkg::bi_intv_t ik, int off);
		bwt_pkg::cand_vec_t c;
		for (int b = 0; b < 4; b++) begin
			c[b].x0 = ik.x0 + 64'(b) + 64'd1;
			c[b].x1 = ik.x1 + 64'(b * 16);
			c[b].x2 = ik.x2 - 64'(b) - 64'(off);
		end
		return c;
	endfunction

	function automatic req_t build_req(bwt_pkg::status_e st, logic [7:0] q, bwt_pkg::bi_intv_t ik,
			logic [63:0] info, int fwd, int min, int off);
		req_t r;
		r.status = st;
		r.query  = q;
		r.ik     = ik;
		r.info   = info;
		r.fwd    = `BWT_PTR_W'(fwd);
		r.min    = `BWT_PTR_W'(min);
		r.rn     = `BWT_READ_NUM_W'(req_count);
		r.ptr    = `BWT_PTR_W'(req_count * 5);
		r.bx     = `BWT_PTR_W'(req_count);
		r.cand   = make_cand(ik, off);
		req_count++;
		return r;
	endfunction

	function automatic req_t bubble_req();
		req_t r;
		r        = '0;
		r.status = bwt_pkg::BUBBLE;
		return r;
	endfunction

	function automatic logic [63:0] skip_primary(logic [63:0] v);
		return (v >= PRIMARY) ? v - 64'd1 : v;
	endfunction

	// expected outputs of one request at every tap of the pipeline
	function automatic exp_t ref_forward(req_t r);
		exp_t              e;
		bwt_pkg::status_e  st;
		bwt_pkg::bi_intv_t sel;
		logic              upd;
		logic [63:0]       k;
		logic [63:0]       l;
		e         = '0;
		e.live    = r.status != bwt_pkg::BUBBLE;
		st        = r.status;
		upd       = 1'b0;
		if (st == bwt_pkg::F_RUN && r.fwd >= `BWT_LEN) begin
			st         = bwt_pkg::F_BREAK; // read fully extended
			e.occ_done = 1'b1;
		end
		e.occ_k     = skip_primary(r.ik.x1 - 64'd1);
		e.occ_l     = skip_primary(r.ik.x1 - 64'd1 + r.ik.x2);
		sel         = r.cand[3 - int'(r.query[1:0])];
		e.curr_addr = r.ptr;
		e.curr_data = {r.info, r.ik.x2, r.ik.x1, r.ik.x0};
		e.curr_rn   = r.rn;
		e.ret       = r.info[`BWT_PTR_W-1:0];
		e.ptr       = r.ptr;
		e.ik        = r.ik;
		e.ik_info   = r.info;
		e.fwd       = r.fwd;
		if (st == bwt_pkg::F_RUN) begin
			upd = 1'b1;
			if (sel.x2 != r.ik.x2) begin
				e.curr_we = 1'b1;
				e.ptr     = r.ptr + 1;
				if (sel.x2 < 64'(r.min)) begin
					st  = bwt_pkg::F_BREAK;
					upd = 1'b0;
				end
			end
		end else if (st == bwt_pkg::F_BREAK) begin
			e.curr_we   = r.fwd == `BWT_LEN;
			e.ptr       = e.curr_we ? r.ptr + 1 : r.ptr;
			e.ret_valid = 1'b1;
			st          = bwt_pkg::BCK_INI;
		end
		if (upd) begin
			e.ik      = sel;
			e.ik_info = 64'(r.fwd) + 64'd1;
			e.fwd     = r.fwd + 1;
		end
		e.q_status   = st;
		e.q_pos      = e.fwd;
		e.dram_valid = (st == bwt_pkg::F_INIT) || (st == bwt_pkg::F_RUN);
		k            = skip_primary(e.ik.x1 - 64'd1);
		l            = skip_primary(e.ik.x1 - 64'd1 + e.ik.x2);
		if (e.dram_valid) begin
			e.addr_k = {k[`BWT_ADDR_HI:`BWT_ADDR_LO], 4'b0};
			e.addr_l = {l[`BWT_ADDR_HI:`BWT_ADDR_LO], 4'b0};
		end
		e.st_out = (st == bwt_pkg::F_INIT) ? bwt_pkg::F_RUN : st;
		e.rn     = r.rn;
		e.query  = r.query;
		e.min    = r.min;
		e.bx     = r.bx;
		return e;
	endfunction

	function automatic exp_t exp_at(int idx);
		if (idx < 0 || idx >= exp_q.size()) begin
			return ref_forward(bubble_req()); // pipeline still holds reset bubbles
		end
		return exp_q[idx];
	endfunction

	task automatic report_error();
		n_errors++;
		test_errors++;
	endtask

	task automatic check_status(string name, bwt_pkg::status_e exp, bwt_pkg::status_e act);
		n_checks++;
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %s got %s (%0h)", $time, name, exp.name(),
				act.name(), act);
			report_error();
		end
	endtask

	task automatic check_intv(string name, bwt_pkg::bi_intv_t exp, bwt_pkg::bi_intv_t act);
		n_checks++;
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
			report_error();
		end
	endtask

	task automatic check_bits(string name, logic [255:0] exp, logic [255:0] act);
		n_checks++;
		if (act !== exp) begin
			$display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
			report_error();
		end
	endtask

	// ------------------------------------------------------------
	// checker, every cycle including stalled ones
	// ------------------------------------------------------------
	task automatic compare_outputs();
		exp_t e;
		e = exp_at(adv - 1); // seed stage
		check_bits("occ_done_o", 256'(e.occ_done), 256'(occ_done_o));
		if (e.live) begin
			check_bits("occ_k_o", 256'(e.occ_k), 256'(occ_k_o));
			check_bits("occ_l_o", 256'(e.occ_l), 256'(occ_l_o));
		end
		e = exp_at(adv - 14); // decide stage
		check_bits("curr_we_o", 256'(e.curr_we), 256'(curr_we_o));
		check_bits("ret_valid_o", 256'(e.ret_valid), 256'(ret_valid_o));
		if (e.curr_we) begin
			check_bits("curr_addr_o", 256'(e.curr_addr), 256'(curr_addr_o));
			check_bits("curr_data_o", e.curr_data, curr_data_o);
			check_bits("curr_read_num_o", 256'(e.curr_rn), 256'(curr_read_num_o));
		end
		if (e.ret_valid) begin
			check_bits("ret_o", 256'(e.ret), 256'(ret_o));
			check_bits("ret_read_num_o", 256'(e.curr_rn), 256'(ret_read_num_o));
		end
		e = exp_at(adv - 16); // query request
		check_status("query_status_o", e.q_status, query_status_o);
		if (e.live) begin
			check_bits("query_read_num_o", 256'(e.rn), 256'(query_read_num_o));
			check_bits("next_query_pos_o", 256'(e.q_pos), 256'(next_query_pos_o));
		end
		e = exp_at(adv - 17); // DRAM request and context out
		check_bits("dram_valid_o", 256'(e.dram_valid), 256'(dram_valid_o));
		check_status("status_o", e.st_out, status_o);
		if (e.live) begin
			check_bits("addr_k_o", 256'(e.addr_k), 256'(addr_k_o)); // zero when not issued
			check_bits("addr_l_o", 256'(e.addr_l), 256'(addr_l_o));
			check_intv("ik_o", e.ik, ik_o);
			check_bits("ik_info_o", 256'(e.ik_info), 256'(ik_info_o));
			check_bits("ptr_curr_o", 256'(e.ptr), 256'(ptr_curr_o));
			check_bits("forward_i_o", 256'(e.fwd), 256'(forward_i_o));
			check_bits("read_num_o", 256'(e.rn), 256'(read_num_o));
			check_bits("query_o", 256'(e.query), 256'(query_o));
			check_bits("min_intv_o", 256'(e.min), 256'(min_intv_o));
			check_bits("backward_x_o", 256'(e.bx), 256'(backward_x_o));
		end
	endtask

	always @(negedge Clk_32UI) begin
		if (checking) begin
			compare_outputs();
		end
	end

	// drives one slot, sampled at the next rising edge
	task automatic apply_req(req_t r);
		stall_i      = 1'b0;
		status_i     = r.status;
		query_i      = r.query;
		ptr_curr_i   = r.ptr;
		read_num_i   = r.rn;
		ik_i         = r.ik;
		ik_info_i    = r.info;
		forward_i_i  = r.fwd;
		min_intv_i   = r.min;
		backward_x_i = r.bx;
		cur_cand     = r.cand;
		exp_q.push_back(ref_forward(r));
	endtask

	task automatic send_req(req_t r);
		@(posedge Clk_32UI);
		#1;
		apply_req(r);
	endtask

	task automatic send_stall();
		@(posedge Clk_32UI);
		#1;
		stall_i = 1'b1; // other inputs hold
		n_stalls++;
	endtask

	task automatic finish_test(int num, string name);
		repeat (DRAIN) send_req(bubble_req());
		$display("test %0d %s: done, %0d mismatches", num, name, test_errors);
		test_errors = 0;
	endtask

	function automatic req_t rand_req();
		bwt_pkg::status_e  st;
		bwt_pkg::bi_intv_t ik;
		logic [31:0]       sel;
		int                fwd;
		sel = next_rand() % 4;
		st  = (sel == 0) ? bwt_pkg::F_INIT : (sel == 3) ? bwt_pkg::F_BREAK : bwt_pkg::F_RUN;
		ik  = intv({next_rand(), next_rand()}, PRIMARY + 64'(next_rand() % 512) - 64'd256,
			64'(next_rand() % 300));
		fwd = (next_rand() % 2 == 0) ? 95 + int'(next_rand() % 10) : int'(next_rand() % 128);
		return build_req(st, next_rand() % 256, ik, {next_rand(), next_rand()}, fwd,
			int'(next_rand() % 128), int'(next_rand() % 4));
	endfunction

	initial begin
		reset_BWT_extend = 1'b0;
		primary_i        = PRIMARY;
		for (int i = 0; i <= `BWT_OCC_LATENCY; i++) begin
			cand_pipe[i] <= '0;
		end
		apply_req(bubble_req());
		exp_q.delete(); // nothing is sampled during reset
		@(posedge Clk_32UI);
		#1;
		checking = 1'b1; // outputs hold their reset values from here on
		repeat (7) @(posedge Clk_32UI);
		#1;
		reset_BWT_extend = 1'b1;
		apply_req(bubble_req());
		finish_test(1, "reset state");

		send_req(build_req(bwt_pkg::F_INIT, 8'd0, intv(64'h11, PRIMARY - 64'd100, 64'd50),
			64'h5, 0, 0, 0));
		send_req(build_req(bwt_pkg::F_INIT, 8'd1, intv(64'h22, PRIMARY + 64'd1, 64'd9),
			64'h6, 0, 0, 1));
		send_req(build_req(bwt_pkg::F_INIT, 8'd2, intv(64'h33, PRIMARY - 64'd10, 64'd11),
			64'h7, 0, 0, 2));
		finish_test(2, "init lookup around primary");

		send_req(build_req(bwt_pkg::F_RUN, 8'd2, intv(64'h100, PRIMARY + 64'h8000, 64'd1000),
			64'h14, 20, 5, 3));
		send_req(build_req(bwt_pkg::F_RUN, 8'd0, intv(64'h200, PRIMARY - 64'h8000, 64'd500),
			64'h30, 48, 100, 2));
		finish_test(3, "run with shrinking interval");

		send_req(build_req(bwt_pkg::F_RUN, 8'd1, intv(64'h300, PRIMARY, 64'd10),
			64'h40, 33, 20, 1));
		send_req(build_req(bwt_pkg::F_RUN, 8'd3, intv(64'h400, PRIMARY + 64'd3, 64'd77),
			64'h41, 60, 10, 0));
		send_req(build_req(bwt_pkg::F_RUN, 8'd2, intv(64'h500, PRIMARY, 64'd90),
			64'h42, 105, 10, 1));
		finish_test(4, "break, equal interval and read end");

		send_req(build_req(bwt_pkg::F_BREAK, 8'd0, intv(64'h600, PRIMARY, 64'd5),
			64'h1234_5645, `BWT_LEN, 0, 0));
		send_req(build_req(bwt_pkg::F_BREAK, 8'd1, intv(64'h700, PRIMARY, 64'd6),
			64'h0000_0abc, 50, 0, 0));
		finish_test(5, "break return");

		for (int n = 0; n < N_RANDOM; n++) begin
			if (next_rand() % 4 == 0) begin
				send_stall();
			end
			send_req(rand_req());
		end
		finish_test(6, "random back to back with stalls");

		$display("checks %0d, errors %0d, stall cycles %0d, cycles %0d", n_checks, n_errors,
			n_stalls, cycle_cnt);
		if (n_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+include
logic/bwt_pkg.sv
logic/fwd_seed_stage.sv
logic/ctx_delay_line.sv
logic/fwd_decide_stage.sv
logic/fwd_update_stage.sv
logic/mem_issue_stage.sv
logic/fwd_extend_top.sv
test/fwd_extend_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = fwd_extend_tb
FILELIST = vlog.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@! grep -q "Result: FAILED" $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
